//--- src/msx_io_pkg.sv
package msx_io_pkg;

    // PSG I/O ports
    localparam logic [7:0] PORT_PSG_ADDR  = 8'hA0;
    localparam logic [7:0] PORT_PSG_WRITE = 8'hA1;
    localparam logic [7:0] PORT_PSG_READ  = 8'hA2;

    // PPI I/O ports
    localparam logic [7:0] PORT_PPI_A    = 8'hA8;
    localparam logic [7:0] PORT_PPI_B    = 8'hA9;
    localparam logic [7:0] PORT_PPI_C    = 8'hAA;
    localparam logic [7:0] PORT_PPI_CTRL = 8'hAB;

    localparam logic [3:0] PSG_REG_IO_A = 4'd14;                    // Joystick and tape input
    localparam logic [3:0] PSG_REG_IO_B = 4'd15;                    // Joystick select and pins

    // Device select vector
    localparam int DEV_PSG   = 0;
    localparam int DEV_PPI   = 1;
    localparam int DEV_COUNT = 2;

    localparam logic [7:0] BUS_IDLE = 8'hFF;                        // Pulled-up data bus

    // 8255 mode definition word, bit 7 set
    typedef struct packed {
        logic       mode_set;
        logic [1:0] mode_a;                                         // Group A mode
        logic       dir_a;                                          // 1 = input
        logic       dir_c_hi;
        logic       mode_b;                                         // Group B mode
        logic       dir_b;
        logic       dir_c_lo;
    } ppi_mode_t;

    // 8255 port C bit set/reset word, bit 7 clear
    typedef struct packed {
        logic       mode_set;
        logic [2:0] unused;
        logic [2:0] bit_sel;
        logic       value;
    } ppi_bsr_t;

    typedef union packed {
        ppi_mode_t mode;
        ppi_bsr_t  bsr;
    } ppi_ctrl_t;

    localparam logic [7:0] PPI_C_RESET    = 8'h00;
    localparam logic [7:0] PPI_SLOT_RESET = 8'h00;
    localparam logic [7:0] PPI_MODE_RESET = 8'h82;                  // A out, B in, C out as set by BIOS

endpackage

//--- src/io_decode.sv
`timescale 1ns/10ps

module io_decode import msx_io_pkg::*; (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 req_valid,
    output logic                 req_ready,
    input  logic                 req_write,
    input  logic [7:0]           req_port,
    input  logic [7:0]           req_wdata,
    input  logic                 fire,
    output logic                 stage_valid,
    output logic [DEV_COUNT-1:0] stage_sel,
    output logic                 stage_write,
    output logic [7:0]           stage_port,
    output logic [7:0]           stage_wdata
);

    logic                 ready_en;                                 // Low until first edge after reset
    logic                 accept;
    logic [DEV_COUNT-1:0] sel_d;

    assign req_ready = ready_en & (~stage_valid | fire);
    assign accept    = req_valid & req_ready;

    // Port ranges to one-hot select, unmapped gives zero
    always_comb begin
        sel_d = '0;
        if (req_port >= PORT_PSG_ADDR && req_port <= PORT_PSG_READ) begin
            sel_d[DEV_PSG] = 1'b1;
        end else if (req_port >= PORT_PPI_A && req_port <= PORT_PPI_CTRL) begin
            sel_d[DEV_PPI] = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ready_en    <= 1'b0;
            stage_valid <= 1'b0;
        end else begin
            ready_en <= 1'b1;
            if (accept) begin
                stage_valid <= 1'b1;                                // Refill on the same edge as fire
            end else if (fire) begin
                stage_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            stage_sel   <= sel_d;
            stage_write <= req_write;
            stage_port  <= req_port;
            stage_wdata <= req_wdata;
        end
    end

endmodule

//--- src/dev_ppi.sv
`timescale 1ns/10ps

module dev_ppi import msx_io_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       fire,
    input  logic       sel,
    input  logic       write,
    input  logic [7:0] port,
    input  logic [7:0] wdata,
    output logic [7:0] rdata,
    output logic [7:0] slot_config,
    output logic [3:0] kb_row,
    output logic       keybeep,
    output logic       tape_motor_on,
    input  logic [7:0] kb_cols
);

    logic [7:0] slot_q;                                             // Primary slot per page
    logic [7:0] port_c_q;
    ppi_ctrl_t  mode_q;
    ppi_ctrl_t  ctrl;
    logic       wr_en;
    logic       rd_en;
    logic [3:0] c_hi;
    logic [3:0] c_lo;

    assign ctrl  = ppi_ctrl_t'(wdata);
    assign wr_en = fire & sel & write;
    assign rd_en = sel & ~write;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            slot_q   <= PPI_SLOT_RESET;
            port_c_q <= PPI_C_RESET;
            mode_q   <= ppi_ctrl_t'(PPI_MODE_RESET);
        end else if (wr_en) begin
            case (port)
                PORT_PPI_A: begin
                    slot_q <= wdata;
                end
                PORT_PPI_C: begin
                    port_c_q <= wdata;
                end
                PORT_PPI_CTRL: begin
                    if (ctrl.mode.mode_set) begin
                        mode_q   <= ctrl;
                        port_c_q <= PPI_C_RESET;                    // Mode set clears outputs
                    end else begin
                        port_c_q[ctrl.bsr.bit_sel] <= ctrl.bsr.value;
                    end
                end
                default: begin
                end
            endcase
        end
    end

    // Port C halves set to input read as pulled-up pins
    assign c_hi = mode_q.mode.dir_c_hi ? 4'hF : port_c_q[7:4];
    assign c_lo = mode_q.mode.dir_c_lo ? 4'hF : port_c_q[3:0];

    always_comb begin
        rdata = BUS_IDLE;
        if (rd_en) begin
            case (port)
                PORT_PPI_A: rdata = slot_q;
                PORT_PPI_B: rdata = kb_cols;                        // Columns of selected row
                PORT_PPI_C: rdata = {c_hi, c_lo};
                default:    rdata = BUS_IDLE;                       // Control port is write only
            endcase
        end
    end

    assign slot_config   = slot_q;
    assign kb_row        = port_c_q[3:0];
    assign tape_motor_on = port_c_q[4];                             // Active high here
    assign keybeep       = port_c_q[7];

endmodule

//--- src/dev_psg.sv
`timescale 1ns/10ps

module dev_psg import msx_io_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       fire,
    input  logic       sel,
    input  logic       write,
    input  logic [7:0] port,
    input  logic [7:0] wdata,
    output logic [7:0] rdata,
    input  logic [5:0] joy_a,
    input  logic [5:0] joy_b,
    input  logic       tape_in
);

    logic [3:0] addr_q;                                             // Latched register index
    logic [7:0] regs_q [16];
    logic       wr_en;
    logic       rd_en;
    logic [5:0] joy_sel;

    assign wr_en = fire & sel & write;
    assign rd_en = sel & ~write;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            addr_q <= '0;
            for (int i = 0; i < 16; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wr_en) begin
            case (port)
                PORT_PSG_ADDR: begin
                    addr_q <= wdata[3:0];
                end
                PORT_PSG_WRITE: begin
                    regs_q[addr_q] <= wdata;
                end
                default: begin
                end
            endcase
        end
    end

    // Register 15 bit 6 picks the joystick port
    assign joy_sel = regs_q[PSG_REG_IO_B][6] ? joy_b : joy_a;

    always_comb begin
        rdata = BUS_IDLE;
        if (rd_en && port == PORT_PSG_READ) begin
            if (addr_q == PSG_REG_IO_A) begin
                rdata = {tape_in, 1'b1, joy_sel};
            end else begin
                rdata = regs_q[addr_q];
            end
        end
    end

endmodule

//--- src/io_result.sv
`timescale 1ns/10ps

module io_result (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       stage_valid,
    input  logic [7:0] psg_rdata,
    input  logic [7:0] ppi_rdata,
    output logic       fire,
    output logic       resp_valid,
    input  logic       resp_ready,
    output logic [7:0] resp_rdata
);

    logic [7:0] merged;

    // Idle devices drive 0xFF, so AND picks the selected one
    assign merged = psg_rdata & ppi_rdata;

    // Move stage forward when the slot is free or being drained
    assign fire = stage_valid & (~resp_valid | resp_ready);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            resp_valid <= 1'b0;
        end else if (fire) begin
            resp_valid <= 1'b1;
        end else if (resp_ready) begin
            resp_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            resp_rdata <= merged;                                   // Held while stalled
        end
    end

endmodule

//--- src/msx_devices.sv
`timescale 1ns/10ps

module msx_devices import msx_io_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       req_valid,
    output logic       req_ready,
    input  logic       req_write,
    input  logic [7:0] req_port,
    input  logic [7:0] req_wdata,
    output logic       resp_valid,
    input  logic       resp_ready,
    output logic [7:0] resp_rdata,
    output logic [7:0] slot_config,
    output logic [3:0] kb_row,
    output logic       keybeep,
    output logic       tape_motor_on,
    input  logic [7:0] kb_cols,
    input  logic [5:0] joy_a,
    input  logic [5:0] joy_b,
    input  logic       tape_in
);

    logic                 stage_valid;
    logic [DEV_COUNT-1:0] stage_sel;
    logic                 stage_write;
    logic [7:0]           stage_port;
    logic [7:0]           stage_wdata;
    logic                 fire;
    logic [7:0]           psg_rdata;
    logic [7:0]           ppi_rdata;

    io_decode io_decode_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .req_valid   (req_valid),
        .req_ready   (req_ready),
        .req_write   (req_write),
        .req_port    (req_port),
        .req_wdata   (req_wdata),
        .fire        (fire),
        .stage_valid (stage_valid),
        .stage_sel   (stage_sel),
        .stage_write (stage_write),
        .stage_port  (stage_port),
        .stage_wdata (stage_wdata)
    );

    dev_ppi dev_ppi_i (
        .clk           (clk),
        .arst_n        (arst_n),
        .fire          (fire),
        .sel           (stage_sel[DEV_PPI]),
        .write         (stage_write),
        .port          (stage_port),
        .wdata         (stage_wdata),
        .rdata         (ppi_rdata),
        .slot_config   (slot_config),
        .kb_row        (kb_row),
        .keybeep       (keybeep),
        .tape_motor_on (tape_motor_on),
        .kb_cols       (kb_cols)
    );

    dev_psg dev_psg_i (
        .clk     (clk),
        .arst_n  (arst_n),
        .fire    (fire),
        .sel     (stage_sel[DEV_PSG]),
        .write   (stage_write),
        .port    (stage_port),
        .wdata   (stage_wdata),
        .rdata   (psg_rdata),
        .joy_a   (joy_a),
        .joy_b   (joy_b),
        .tape_in (tape_in)
    );

    io_result io_result_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .stage_valid (stage_valid),
        .psg_rdata   (psg_rdata),
        .ppi_rdata   (ppi_rdata),
        .fire        (fire),
        .resp_valid  (resp_valid),
        .resp_ready  (resp_ready),
        .resp_rdata  (resp_rdata)
    );

endmodule

//--- tb/msx_devices_checker.sv
`timescale 1ns/10ps

module msx_devices_checker (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       req_ready,
    input  logic       stage_valid,
    input  logic       resp_valid,
    input  logic       resp_ready,
    input  logic [7:0] resp_rdata
);

    // Pipeline empty and closed while in reset
    reset_idle: assert property (@(posedge clk)
        !arst_n |-> !resp_valid && !req_ready && !stage_valid)
        else $error("resp_valid, req_ready or stage_valid high during reset");

    resp_hold: assert property (@(posedge clk) disable iff (!arst_n)
        resp_valid && !resp_ready |=> resp_valid && $stable(resp_rdata))
        else $error("Stalled response dropped or resp_rdata changed");

    // Full stage behind a stalled response cannot take more
    full_not_ready: assert property (@(posedge clk) disable iff (!arst_n)
        resp_valid && !resp_ready && stage_valid |-> !req_ready)
        else $error("req_ready high with stage full and response stalled");

endmodule

//--- tb/tb_msx_devices.sv
`timescale 1ns/10ps

module tb_msx_devices import msx_io_pkg::*; ();

    localparam int CLK_PERIOD   = 100;
    localparam int DRIVE_DLY    = 1;
    localparam int RESET_CYCLES = 5;
    localparam int RAND_SEED    = 52813;
    localparam int WAIT_LIMIT   = 16;                               // Cycles per handshake
    localparam int N_SLOT       = 8;
    localparam int N_JOY        = 6;
    localparam int N_PIPE       = 40;
    localparam int TOTAL_REQS   = 5 + 2 * N_SLOT + 59 + 56 + 4 * N_JOY + 2 * N_PIPE;

    logic       clk;
    logic       arst_n;
    logic       req_valid;
    logic       req_ready;
    logic       req_write;
    logic [7:0] req_port;
    logic [7:0] req_wdata;
    logic       resp_valid;
    logic       resp_ready;
    logic [7:0] resp_rdata;
    logic [7:0] slot_config;
    logic [3:0] kb_row;
    logic       keybeep;
    logic       tape_motor_on;
    logic [7:0] kb_cols;
    logic [5:0] joy_a;
    logic [5:0] joy_b;
    logic       tape_in;
    logic [7:0] kb_model [16];
    logic [7:0] psg_model [16];
    logic [7:0] slot_model;
    logic [3:0] psg_idx;
    int         cycle_cnt = 0;
    int         checks_run;
    int         checks_failed;

    msx_devices dut_i (
        .clk           (clk),
        .arst_n        (arst_n),
        .req_valid     (req_valid),
        .req_ready     (req_ready),
        .req_write     (req_write),
        .req_port      (req_port),
        .req_wdata     (req_wdata),
        .resp_valid    (resp_valid),
        .resp_ready    (resp_ready),
        .resp_rdata    (resp_rdata),
        .slot_config   (slot_config),
        .kb_row        (kb_row),
        .keybeep       (keybeep),
        .tape_motor_on (tape_motor_on),
        .kb_cols       (kb_cols),
        .joy_a         (joy_a),
        .joy_b         (joy_b),
        .tape_in       (tape_in)
    );

    bind msx_devices msx_devices_checker checker_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .req_ready   (req_ready),
        .stage_valid (stage_valid),
        .resp_valid  (resp_valid),
        .resp_ready  (resp_ready),
        .resp_rdata  (resp_rdata)
    );

    assign kb_cols = kb_model[kb_row];                              // Keyboard matrix

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    task automatic check_byte(input string what, input logic [7:0] got, input logic [7:0] exp);
        checks_run++;
        assert (got === exp) else begin
            $display("ERROR %s: got 0x%h, expected 0x%h", what, got, exp);
            checks_failed++;
        end
    endtask

    // One request, wait for its response, compare read data
    task automatic bus_transfer(input logic wr, input logic [7:0] port, input logic [7:0] wdata,
                                input logic [7:0] exp);
        int waited;
        req_valid  = 1'b1;
        req_write  = wr;
        req_port   = port;
        req_wdata  = wdata;
        resp_ready = 1'b1;
        waited     = 0;
        @(negedge clk);
        while (!req_ready && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        @(posedge clk);
        #DRIVE_DLY;
        req_valid = 1'b0;
        waited    = 0;
        @(negedge clk);
        while (!resp_valid && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (resp_valid) begin
            check_byte($sformatf("resp_rdata (port 0x%h)", port), resp_rdata, exp);
        end else begin
            $display("No response arrived for the access to port 0x%h", port);
            checks_failed++;
        end
        @(posedge clk);
        #DRIVE_DLY;
    endtask

    task automatic report_test(input string name, input int fails_before);
        $display("%-20s %s", name, (checks_failed == fails_before) ? "ok" : "FAILED");
    endtask

    task automatic reset_defaults();
        int fails0;
        fails0 = checks_failed;
        check_byte("slot_config", slot_config, 8'h00);
        check_byte("keybeep", {7'd0, keybeep}, 8'h00);
        check_byte("tape_motor_on", {7'd0, tape_motor_on}, 8'h00);
        bus_transfer(1'b0, 8'h00, 8'h00, BUS_IDLE);
        bus_transfer(1'b0, 8'h98, 8'h00, BUS_IDLE);                 // VDP is not mapped here
        bus_transfer(1'b0, PORT_PPI_CTRL, 8'h00, BUS_IDLE);
        bus_transfer(1'b1, 8'h98, 8'h5A, BUS_IDLE);
        bus_transfer(1'b1, PORT_PSG_ADDR, 8'h00, BUS_IDLE);
        psg_idx = 4'd0;
        report_test("reset_defaults", fails0);
    endtask

    task automatic slot_register();
        int         fails0;
        logic [7:0] data;
        fails0 = checks_failed;
        for (int i = 0; i < N_SLOT; i++) begin
            data = 8'($urandom);
            bus_transfer(1'b1, PORT_PPI_A, data, BUS_IDLE);
            check_byte("slot_config", slot_config, data);
            bus_transfer(1'b0, PORT_PPI_A, 8'h00, data);
            slot_model = data;
        end
        report_test("slot_register", fails0);
    endtask

    task automatic keyboard_port_c();
        int         fails0;
        logic [7:0] c_model;
        fails0 = checks_failed;
        for (int row = 0; row < 16; row++) begin
            c_model = 8'(row);
            bus_transfer(1'b1, PORT_PPI_C, c_model, BUS_IDLE);
            check_byte("kb_row", {4'h0, kb_row}, c_model);
            bus_transfer(1'b0, PORT_PPI_B, 8'h00, kb_model[4'(row)]);
            bus_transfer(1'b0, PORT_PPI_C, 8'h00, c_model);
        end
        // Set 7, set 4, clear 7, clear 4
        for (int k = 0; k < 4; k++) begin
            logic [2:0] bit_sel;
            logic       val;
            bit_sel = (k % 2 == 0) ? 3'd7 : 3'd4;
            val     = (k < 2);
            c_model[bit_sel] = val;
            bus_transfer(1'b1, PORT_PPI_CTRL, {4'b0000, bit_sel, val}, BUS_IDLE);
            check_byte("keybeep", {7'd0, keybeep}, {7'd0, c_model[7]});
            check_byte("tape_motor_on", {7'd0, tape_motor_on}, {7'd0, c_model[4]});
            bus_transfer(1'b0, PORT_PPI_C, 8'h00, c_model);
        end
        bus_transfer(1'b1, PORT_PPI_C, 8'h9A, BUS_IDLE);
        bus_transfer(1'b1, PORT_PPI_CTRL, 8'h82, BUS_IDLE);         // Mode 0, A out, B in, C out
        check_byte("keybeep,tape_motor_on,kb_row", {keybeep, 2'b00, tape_motor_on, kb_row}, 8'h00);
        bus_transfer(1'b0, PORT_PPI_C, 8'h00, 8'h00);
        report_test("keyboard_port_c", fails0);
    endtask

    task automatic psg_registers();
        int         fails0;
        logic [7:0] data;
        logic       sel_b;
        fails0 = checks_failed;
        for (int r = 0; r < 14; r++) begin
            data = 8'($urandom);
            psg_model[4'(r)] = data;
            bus_transfer(1'b1, PORT_PSG_ADDR, 8'(r), BUS_IDLE);
            bus_transfer(1'b1, PORT_PSG_WRITE, data, BUS_IDLE);
        end
        for (int r = 0; r < 14; r++) begin
            bus_transfer(1'b1, PORT_PSG_ADDR, 8'(r), BUS_IDLE);
            bus_transfer(1'b0, PORT_PSG_READ, 8'h00, psg_model[4'(r)]);
        end
        for (int j = 0; j < N_JOY; j++) begin
            sel_b   = j[0];
            joy_a   = 6'($urandom);
            joy_b   = 6'($urandom);
            tape_in = 1'($urandom);
            data    = (8'($urandom) & 8'hBF) | {1'b0, sel_b, 6'h00};
            psg_model[PSG_REG_IO_B] = data;
            bus_transfer(1'b1, PORT_PSG_ADDR, {4'h0, PSG_REG_IO_B}, BUS_IDLE);
            bus_transfer(1'b1, PORT_PSG_WRITE, data, BUS_IDLE);
            bus_transfer(1'b1, PORT_PSG_ADDR, {4'h0, PSG_REG_IO_A}, BUS_IDLE);
            bus_transfer(1'b0, PORT_PSG_READ, 8'h00, {tape_in, 1'b1, sel_b ? joy_b : joy_a});
        end
        psg_idx = PSG_REG_IO_A;
        report_test("psg_registers", fails0);
    endtask

    // Back-to-back mixed traffic, optionally with response stalls
    task automatic pipelined_traffic(input string name, input bit stall_en);
        logic [7:0] exp_q [$];
        int         hs_q [$];
        int         fails0;
        int         received;
        int         run_left;
        int         op;
        int         latency;
        logic [7:0] data;
        fails0   = checks_failed;
        received = 0;
        run_left = 0;
        fork
            begin
                for (int i = 0; i < N_PIPE; i++) begin
                    op   = (i == 0) ? 3 : int'($urandom % 6);       // Index first, never 14
                    data = 8'($urandom);
                    case (op)
                        0, 1:    req_port = PORT_PPI_A;
                        2:       req_port = {3'b000, data[4:0]};    // Below every mapped range
                        3:       req_port = PORT_PSG_ADDR;
                        4:       req_port = PORT_PSG_WRITE;
                        default: req_port = PORT_PSG_READ;
                    endcase
                    if (op == 3) begin
                        data = {4'h0, 4'(data % 14)};
                    end
                    req_valid = 1'b1;
                    req_write = (op == 0 || op == 3 || op == 4);
                    req_wdata = data;
                    @(negedge clk);
                    while (!req_ready) begin
                        @(negedge clk);
                    end
                    case (op)
                        0:       slot_model = data;
                        3:       psg_idx = data[3:0];
                        4:       psg_model[psg_idx] = data;
                        default: begin
                        end
                    endcase
                    exp_q.push_back(op == 1 ? slot_model : op == 5 ? psg_model[psg_idx] : BUS_IDLE);
                    hs_q.push_back(cycle_cnt);
                    @(posedge clk);
                    #DRIVE_DLY;
                end
                req_valid = 1'b0;
            end
            begin
                while (received < N_PIPE) begin
                    if (stall_en) begin
                        if (run_left == 0) begin
                            resp_ready = ~resp_ready;
                            run_left   = 1 + int'($urandom % 4);
                        end
                        run_left--;
                    end
                    @(negedge clk);
                    if (resp_valid && resp_ready && exp_q.size() == 0) begin
                        $display("Response arrived with no request outstanding");
                        checks_failed++;
                    end else if (resp_valid && resp_ready) begin
                        latency = cycle_cnt - hs_q.pop_front();
                        check_byte("resp_rdata", resp_rdata, exp_q.pop_front());
                        if (!stall_en) begin
                            checks_run++;
                            assert (latency == 2) else begin
                                $display("Response came %0d cycles after acceptance, not 2", latency);
                                checks_failed++;
                            end
                        end
                    end
                    received += (resp_valid && resp_ready) ? 1 : 0;
                    @(posedge clk);
                    #DRIVE_DLY;
                end
                resp_ready = 1'b1;
            end
        join
        report_test(name, fails0);
    endtask

    initial begin
        #(TOTAL_REQS * 20 * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles, run aborted", TOTAL_REQS * 20);
        $display("Testbench failed");
        $finish;
    end

    initial begin
        void'($urandom(RAND_SEED));
        arst_n        = 1'b0;
        req_valid     = 1'b0;
        req_write     = 1'b0;
        req_port      = 8'h00;
        req_wdata     = 8'h00;
        resp_ready    = 1'b1;
        joy_a         = 6'h00;
        joy_b         = 6'h00;
        tape_in       = 1'b0;
        checks_run    = 0;
        checks_failed = 0;
        slot_model    = 8'h00;
        psg_idx       = 4'd0;
        for (int r = 0; r < 16; r++) begin
            kb_model[4'(r)]  = 8'($urandom);
            psg_model[4'(r)] = 8'h00;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DLY;
        arst_n = 1'b1;
        @(posedge clk);
        #DRIVE_DLY;
        reset_defaults();
        slot_register();
        keyboard_port_c();
        psg_registers();
        pipelined_traffic("pipeline_no_stall", 1'b0);
        pipelined_traffic("pipeline_stall", 1'b1);
        $display("Summary: %0d checks, %0d failed", checks_run, checks_failed);
        if (checks_failed == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

//--- filelist.f
src/msx_io_pkg.sv
src/io_decode.sv
src/dev_ppi.sv
src/dev_psg.sv
src/io_result.sv
src/msx_devices.sv
tb/msx_devices_checker.sv
tb/tb_msx_devices.sv

//--- run.sh
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -j 0 \
        -f filelist.f --top-module tb_msx_devices; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/Vtb_msx_devices 2>&1)
sim_status=$?
echo "$sim_out"

if [ "$sim_status" -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "Testbench passed"; then
    exit 0
else
    exit 1
fi
